//--- files.f
rtl/mipsPkg.sv
rtl/memBus.sv
rtl/mipsController.sv
rtl/fetchUnit.sv
rtl/regFile.sv
rtl/mipsAlu.sv
rtl/dataMemory.sv
rtl/mipsCore.sv
+incdir+verification
verification/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mipsCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCoreTb -f files.f -o simv

./obj_dir/simv > sim.log
cat sim.log

# exits non-zero when the pass line is missing
grep -q "^Finished with no errors$" sim.log

//--- verification/tbPrograms.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// instruction encoders, arguments are truncated to their field widths
function automatic logic [31:0] encR(input int rs, input int rt, input int rd, input int sh,
                                     input logic [5:0] fn);
    return {OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input int rs, input int rt,
                                     input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] encJ(input logic [5:0] op, input int wordIdx);
    return {op, 26'(wordIdx)};
endfunction

task automatic emit(input logic [31:0] word);
    progMem[progLen] = word;
    progLen++;
endtask

task automatic expectStore(input int addr, input logic [31:0] data, input accessWidthT w);
    expAddr[expCount]  = 32'(addr);
    expData[expCount]  = data;
    expWidth[expCount] = w;
    expCount++;
endtask

// fills progMem and the expected store list for test t
task automatic loadTest(input int t);
    progLen  = 0;
    expCount = 0;
    case (t)
        0: begin
            emit(encI(OpAddiu, 0, 1, 7));
            emit(encI(OpAddiu, 0, 2, -3));
            emit(encR(1, 2, 3, 0, FnAddu));
            emit(encI(OpSw, 0, 3, 'h100));
            expectStore('h100, 32'h4, AccWord);
            emit(encR(2, 1, 4, 0, FnSubu));
            emit(encI(OpSw, 0, 4, 'h104));
            expectStore('h104, 32'hfffffff6, AccWord);
            emit(encR(1, 2, 5, 0, FnAnd));
            emit(encI(OpSw, 0, 5, 'h108));
            expectStore('h108, 32'h5, AccWord);
            emit(encR(1, 2, 6, 0, FnOr));
            emit(encI(OpSw, 0, 6, 'h10c));
            expectStore('h10c, 32'hffffffff, AccWord);
            emit(encR(1, 2, 7, 0, FnXor));
            emit(encI(OpSw, 0, 7, 'h110));
            expectStore('h110, 32'hfffffffa, AccWord);
            emit(encR(2, 1, 8, 0, FnSlt));
            emit(encI(OpSw, 0, 8, 'h114));
            expectStore('h114, 32'h1, AccWord);
            emit(encR(0, 1, 9, 4, FnSll));
            emit(encI(OpSw, 0, 9, 'h118));
            expectStore('h118, 32'h70, AccWord);
            emit(encR(0, 2, 10, 28, FnSrl));
            emit(encI(OpSw, 0, 10, 'h11c));
            expectStore('h11c, 32'hf, AccWord);
            emit({OpSpecial2, 5'd1, 5'd2, 5'd11, 5'd0, FnMul});
            emit(encI(OpSw, 0, 11, 'h120));
            expectStore('h120, 32'hffffffeb, AccWord);
            // ori and xori zero extend
            emit(encI(OpOri, 1, 12, 'h8000));
            emit(encI(OpSw, 0, 12, 'h124));
            expectStore('h124, 32'h8007, AccWord);
            emit(encI(OpXori, 2, 13, 'hffff));
            emit(encI(OpSw, 0, 13, 'h128));
            expectStore('h128, 32'hffff0002, AccWord);
            emit(encI(OpSlti, 2, 14, -2));
            emit(encI(OpSw, 0, 14, 'h12c));
            expectStore('h12c, 32'h1, AccWord);
        end
        1: begin
            emit(encI(OpOri, 0, 1, 'h80f1));
            emit(encI(OpAddiu, 0, 2, 'h7f));
            emit(encI(OpSw, 0, 1, 'h200));
            expectStore('h200, 32'h80f1, AccWord);
            emit(encI(OpSb, 0, 2, 'h201));
            expectStore('h201, 32'h7f, AccByte);
            emit(encI(OpSh, 0, 1, 'h202));
            expectStore('h202, 32'h80f1, AccHalf);
            // memory now holds f1 7f f1 80 from 0x200 up
            emit(encI(OpLb, 0, 3, 'h200));
            emit(encI(OpSw, 0, 3, 'h210));
            expectStore('h210, 32'hfffffff1, AccWord);
            emit(encI(OpLb, 0, 4, 'h201));
            emit(encI(OpSw, 0, 4, 'h214));
            expectStore('h214, 32'h7f, AccWord);
            emit(encI(OpLh, 0, 5, 'h202));
            emit(encI(OpSw, 0, 5, 'h218));
            expectStore('h218, 32'hffff80f1, AccWord);
            emit(encI(OpLw, 0, 6, 'h200));
            emit(encI(OpSw, 0, 6, 'h21c));
            expectStore('h21c, 32'h80f17ff1, AccWord);
            emit(encI(OpLh, 0, 7, 'h200));
            emit(encI(OpSw, 0, 7, 'h220));
            expectStore('h220, 32'h7ff1, AccWord);
        end
        2: begin
            emit(encI(OpAddiu, 0, 1, 5));
            emit(encI(OpAddiu, 0, 2, -1));
            emit(encI(OpAddiu, 0, 3, 5));
            // taken cases skip a store to 0x3f0
            emit(encI(OpBeq, 1, 3, 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 1, 'h300));
            expectStore('h300, 32'h5, AccWord);
            emit(encI(OpBeq, 1, 2, 1));
            emit(encI(OpSw, 0, 1, 'h304));
            expectStore('h304, 32'h5, AccWord);
            emit(encI(OpBne, 1, 2, 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 2, 'h308));
            expectStore('h308, 32'hffffffff, AccWord);
            emit(encI(OpBne, 1, 3, 1));
            emit(encI(OpSw, 0, 2, 'h30c));
            expectStore('h30c, 32'hffffffff, AccWord);
            emit(encI(OpBgtz, 1, 0, 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 1, 'h310));
            expectStore('h310, 32'h5, AccWord);
            emit(encI(OpBgtz, 2, 0, 1));
            emit(encI(OpSw, 0, 2, 'h314));
            expectStore('h314, 32'hffffffff, AccWord);
            emit(encI(OpBlez, 2, 0, 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 1, 'h318));
            expectStore('h318, 32'h5, AccWord);
            emit(encI(OpBlez, 1, 0, 1));
            emit(encI(OpSw, 0, 1, 'h31c));
            expectStore('h31c, 32'h5, AccWord);
            emit(encI(OpRegimm, 2, int'(RtBltz), 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 2, 'h320));
            expectStore('h320, 32'hffffffff, AccWord);
            emit(encI(OpRegimm, 1, int'(RtBltz), 1));
            emit(encI(OpSw, 0, 1, 'h324));
            expectStore('h324, 32'h5, AccWord);
            // bgez on zero is taken
            emit(encI(OpRegimm, 0, int'(RtBgez), 1));
            emit(encI(OpSw, 0, 0, 'h3f0));
            emit(encI(OpSw, 0, 1, 'h328));
            expectStore('h328, 32'h5, AccWord);
            emit(encI(OpRegimm, 2, int'(RtBgez), 1));
            emit(encI(OpSw, 0, 2, 'h32c));
            expectStore('h32c, 32'hffffffff, AccWord);
        end
        3: begin
            emit(encI(OpAddiu, 0, 1, 1));
            emit(encJ(OpJal, 4));
            emit(encI(OpSw, 0, 31, 'h380));
            emit(encJ(OpJ, 3));
            emit(encI(OpSw, 0, 1, 'h384));
            emit(encR(31, 0, 0, 0, FnJr));
            // subroutine store comes first, then the link value
            expectStore('h384, 32'h1, AccWord);
            expectStore('h380, 32'h8, AccWord);
        end
        default: begin
            emit(encI(OpAddiu, 0, 1, 9));
            // opcode 111111 is outside the subset
            emit(32'hfc21ffff);
            emit(encI(OpAddiu, 0, 0, 'h55));
            emit(encR(1, 1, 0, 0, FnAddu));
            emit(encI(OpSw, 0, 0, 'h390));
            expectStore('h390, 32'h0, AccWord);
            emit(encI(OpSw, 0, 1, 'h394));
            expectStore('h394, 32'h9, AccWord);
        end
    endcase
    // park on a jump to itself, except where the program already does
    if (t != 3) begin
        emit(encJ(OpJ, progLen));
    end
endtask

`endif

//--- verification/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam int NumTests = 5;

    logic                     clk;
    logic                     rstN;
    logic                     imemWe;
    logic [ImemAddrWidth-1:0] imemAddr;
    logic [DataWidth-1:0]     imemData;
    logic                     storeValid;
    logic [DataWidth-1:0]     storeAddr;
    logic [DataWidth-1:0]     storeData;
    accessWidthT              storeWidth;

    logic [31:0] progMem [64];
    int          progLen;
    logic [31:0] expAddr [64];
    logic [31:0] expData [64];
    accessWidthT expWidth [64];
    int          expCount;
    int          expIdx;
    logic [31:0] curAddr;
    logic [31:0] curData;
    accessWidthT curWidth;
    logic        inReset;
    int          errCount;
    int          budget;
    logic        budgetReady;

    `include "tbPrograms.svh"

    mipsCore i_mipsCore (
        .clk, .rstN, .imemWe, .imemAddr, .imemData,
        .storeValid, .storeAddr, .storeData, .storeWidth
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // expected store tracking
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        inReset <= !rstN;
        if (!rstN) begin
            expIdx <= 0;
        end else if (storeValid) begin
            expIdx <= expIdx + 1;
        end
    end

    assign curAddr  = expAddr[expIdx[5:0]];
    assign curData  = expData[expIdx[5:0]];
    assign curWidth = expWidth[expIdx[5:0]];

    quietInReset: assert property (@(negedge clk) (!rstN || inReset) |-> !storeValid)
        else begin
            errCount++;
            $display("store issued during reset or the first cycle after it");
        end

    storeExpected: assert property (@(negedge clk) storeValid |-> expIdx < expCount)
        else begin
            errCount++;
            $display("unexpected store at address %h", storeAddr);
        end

    addrMatch: assert property (@(negedge clk)
        (storeValid && expIdx < expCount) |-> storeAddr == curAddr)
        else begin
            errCount++;
            $display("** Error storeAddr: got %h, expected %h", storeAddr, curAddr);
        end

    dataMatch: assert property (@(negedge clk)
        (storeValid && expIdx < expCount) |-> storeData == curData)
        else begin
            errCount++;
            $display("** Error storeData: got %h, expected %h", storeData, curData);
        end

    widthMatch: assert property (@(negedge clk)
        (storeValid && expIdx < expCount) |-> storeWidth == curWidth)
        else begin
            errCount++;
            $display("** Error storeWidth: got %h, expected %h", storeWidth, curWidth);
        end

    //////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////
    initial begin
        wait (budgetReady);
        repeat (budget) @(posedge clk);
        $display("watchdog expired before all stores were seen");
        $display("Finished with errors");
        $finish;
    end

    function automatic string testName(input int t);
        case (t)
            0:       return "alu and immediates";
            1:       return "loads and stores";
            2:       return "branches";
            3:       return "jal and jr";
            default: return "unknown opcode and r0";
        endcase
    endfunction

    initial begin
        int errBefore;
        rstN        = 1'b0;
        imemWe      = 1'b0;
        imemAddr    = '0;
        imemData    = '0;
        errCount    = 0;
        budget      = 0;
        budgetReady = 1'b0;
        for (int t = 0; t < NumTests; t++) begin
            loadTest(t);
            budget += 4 * progLen + 20;
        end
        budgetReady = 1'b1;
        for (int t = 0; t < NumTests; t++) begin
            @(posedge clk);
            #2 rstN = 1'b0;
            loadTest(t);
            errBefore = errCount;
            // decode a store at address 0 while reset is held
            imemWe   = 1'b1;
            imemAddr = '0;
            imemData = encI(OpSw, 0, 0, 'h3f0);
            @(posedge clk);
            #2;
            for (int i = 0; i < progLen; i++) begin
                imemWe   = 1'b1;
                imemAddr = ImemAddrWidth'(i);
                imemData = progMem[i];
                @(posedge clk);
                #2;
            end
            imemWe = 1'b0;
            if (progLen < 10) begin
                repeat (10 - progLen) @(posedge clk);
                #2;
            end
            rstN = 1'b1;
            wait (expIdx == expCount);
            // extra cycles expose stores past the end of the list
            repeat (4) @(posedge clk);
            $display("test %0d (%s): %0d errors", t, testName(t), errCount - errBefore);
        end
        $display("%0d tests run, %0d errors", NumTests, errCount);
        if (errCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- rtl/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              imemWe,
    input  logic [mipsPkg::ImemAddrWidth-1:0] imemAddr,
    input  logic [mipsPkg::DataWidth-1:0]     imemData,
    output logic                              storeValid,
    output logic [mipsPkg::DataWidth-1:0]     storeAddr,
    output logic [mipsPkg::DataWidth-1:0]     storeData,
    output mipsPkg::accessWidthT              storeWidth
);
    import mipsPkg::*;

    logic [DataWidth-1:0] instr;
    logic [DataWidth-1:0] pc;
    logic [DataWidth-1:0] pcPlus4;
    ctrlT                 ctrl;
    logic [DataWidth-1:0] rsData;
    logic [DataWidth-1:0] rtData;
    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] branchOffset;
    logic [DataWidth-1:0] aluB;
    logic [4:0]           aluShamt;
    logic [DataWidth-1:0] aluResult;
    logic                 branchTaken;
    logic [4:0]           destReg;
    logic [DataWidth-1:0] wbData;

    memBus dBus ();

    fetchUnit i_fetchUnit (
        .clk, .rstN, .imemWe, .imemAddr, .imemData,
        .nextPc(ctrl.nextPc), .branchTaken, .jumpTarget(instr[25:0]),
        .branchOffset, .regTarget(rsData), .pc, .pcPlus4, .instr
    );

    mipsController i_mipsController (
        .opcode(instr[31:26]), .funct(instr[5:0]), .rt(instr[20:16]), .ctrl
    );

    regFile i_regFile (
        .clk, .rstN, .we(ctrl.regWrite), .waddr(destReg), .wdata(wbData),
        .raddrA(instr[25:21]), .raddrB(instr[20:16]), .rdataA(rsData), .rdataB(rtData)
    );

    //////////////////////////////////////////////////
    // operand selection
    //////////////////////////////////////////////////
    assign immExt       = ctrl.signExtend ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
    assign branchOffset = {{14{instr[15]}}, instr[15:0], 2'b00};
    assign aluB         = ctrl.aluSrcImm ? immExt : rtData;
    // instruction field for sll/srl, otherwise the low bits of rs
    assign aluShamt     = ctrl.aluSrcShamt ? instr[10:6] : rsData[4:0];

    mipsAlu i_mipsAlu (
        .aluOp(ctrl.aluOp), .a(rsData), .b(aluB), .shamt(aluShamt),
        .nextPc(ctrl.nextPc), .result(aluResult), .branchTaken
    );

    // no stores issued while held in reset
    assign dBus.readEn  = ctrl.memRead;
    assign dBus.writeEn = ctrl.memWrite && rstN;
    assign dBus.width   = ctrl.accessWidth;
    assign dBus.addr    = aluResult;
    assign dBus.wdata   = rtData;

    dataMemory i_dataMemory (.clk, .rstN, .bus(dBus.mem));

    assign storeValid = dBus.writeEn;
    assign storeAddr  = dBus.addr;
    assign storeData  = dBus.wdata;
    assign storeWidth = dBus.width;

    //////////////////////////////////////////////////
    // write back
    //////////////////////////////////////////////////
    always_comb begin
        if (ctrl.resultSel == ResLink) begin
            destReg = LinkReg;
        end else begin
            destReg = ctrl.regDstRd ? instr[15:11] : instr[20:16];
        end
        case (ctrl.resultSel)
            ResMem:  wbData = dBus.rdata;
            ResLink: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

endmodule

//--- rtl/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
    input logic clk,
    input logic rstN,
    memBus.mem  bus
);
    import mipsPkg::*;

    logic [7:0]               mem [DmemDepth];
    logic [DmemAddrWidth-1:0] a0;
    logic [DmemAddrWidth-1:0] a1;
    logic [DmemAddrWidth-1:0] a2;
    logic [DmemAddrWidth-1:0] a3;
    logic [DataWidth-1:0]     loadData;

    // byte lanes of the addressed word
    assign a0 = bus.addr[DmemAddrWidth-1:0];
    assign a1 = a0 + DmemAddrWidth'(1);
    assign a2 = a0 + DmemAddrWidth'(2);
    assign a3 = a0 + DmemAddrWidth'(3);

    // little endian, lowest byte at the lowest address
    always_ff @(posedge clk) begin
        if (bus.writeEn) begin
            mem[a0] <= bus.wdata[7:0];
            if (bus.width != AccByte) begin
                mem[a1] <= bus.wdata[15:8];
            end
            if (bus.width == AccWord) begin
                mem[a2] <= bus.wdata[23:16];
                mem[a3] <= bus.wdata[31:24];
            end
        end
    end

    // half and byte loads sign extend
    always_comb begin
        case (bus.width)
            AccWord: loadData = {mem[a3], mem[a2], mem[a1], mem[a0]};
            AccHalf: loadData = {{16{mem[a1][7]}}, mem[a1], mem[a0]};
            default: loadData = {{24{mem[a0][7]}}, mem[a0]};
        endcase
    end

    assign bus.rdata = bus.readEn ? loadData : '0;

    //////////////////////////////////////////////////
    // alignment per access width
    //////////////////////////////////////////////////
    property accessAligned;
        @(posedge clk) disable iff (!rstN)
        (bus.readEn || bus.writeEn) |->
            ((bus.width == AccByte) ||
             (bus.width == AccHalf && bus.addr[0] == 1'b0) ||
             (bus.width == AccWord && bus.addr[1:0] == 2'b00));
    endproperty

    alignCheck: assert property (accessAligned)
        else $error("misaligned access, addr %h width %s", bus.addr, bus.width.name());

endmodule

//--- rtl/mipsAlu.sv
`timescale 1ns/1ps

module mipsAlu (
    input  mipsPkg::aluOpT                aluOp,
    input  logic [mipsPkg::DataWidth-1:0] a,
    input  logic [mipsPkg::DataWidth-1:0] b,
    input  logic [4:0]                    shamt,
    input  mipsPkg::nextPcT               nextPc,
    output logic [mipsPkg::DataWidth-1:0] result,
    output logic                          branchTaken
);
    import mipsPkg::*;

    logic aIsZero;
    logic aIsNeg;

    always_comb begin
        case (aluOp)
            AluAdd:  result = a + b;
            AluSub:  result = a - b;
            AluAnd:  result = a & b;
            AluOr:   result = a | b;
            AluXor:  result = a ^ b;
            AluSlt:  result = {{(DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            // shifts act on rt, which arrives on b
            AluSll:  result = b << shamt;
            AluSrl:  result = b >> shamt;
            // low word of the product only
            AluMul:  result = a * b;
            default: result = '0;
        endcase
    end

    assign aIsZero = (a == '0);
    assign aIsNeg  = a[DataWidth-1];

    //////////////////////////////////////////////////
    // branch condition
    //////////////////////////////////////////////////
    always_comb begin
        case (nextPc)
            PcBeq:   branchTaken = (a == b);
            PcBne:   branchTaken = (a != b);
            PcBgtz:  branchTaken = !aIsNeg && !aIsZero;
            PcBlez:  branchTaken = aIsNeg || aIsZero;
            PcBltz:  branchTaken = aIsNeg;
            PcBgez:  branchTaken = !aIsNeg;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          we,
    input  logic [4:0]                    waddr,
    input  logic [mipsPkg::DataWidth-1:0] wdata,
    input  logic [4:0]                    raddrA,
    input  logic [4:0]                    raddrB,
    output logic [mipsPkg::DataWidth-1:0] rdataA,
    output logic [mipsPkg::DataWidth-1:0] rdataB
);
    import mipsPkg::*;

    logic [DataWidth-1:0] regs [RegCount];

    // writes to $zero are dropped, nothing lands during reset
    always_ff @(posedge clk) begin
        if (rstN && we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // old value on a same-cycle read
    assign rdataA = (raddrA == 5'd0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? '0 : regs[raddrB];

    writeAddrKnown: assert property (
        @(posedge clk) disable iff (!rstN) we |-> !$isunknown(waddr)
    ) else $error("register write with undefined address");

endmodule

//--- rtl/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              imemWe,
    input  logic [mipsPkg::ImemAddrWidth-1:0] imemAddr,
    input  logic [mipsPkg::DataWidth-1:0]     imemData,
    input  mipsPkg::nextPcT                   nextPc,
    input  logic                              branchTaken,
    input  logic [25:0]                       jumpTarget,
    input  logic [31:0]                       branchOffset,
    input  logic [31:0]                       regTarget,
    output logic [mipsPkg::DataWidth-1:0]     pc,
    output logic [mipsPkg::DataWidth-1:0]     pcPlus4,
    output logic [mipsPkg::DataWidth-1:0]     instr
);
    import mipsPkg::*;

    logic [DataWidth-1:0] imem [ImemDepth];
    logic [DataWidth-1:0] pcNext;
    logic [DataWidth-1:0] branchTarget;
    logic [DataWidth-1:0] jumpAddr;

    // program load port
    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr        = imem[pc[ImemAddrWidth+1:2]];
    assign pcPlus4      = pc + DataWidth'(4);
    assign branchTarget = pcPlus4 + branchOffset;
    assign jumpAddr     = {pcPlus4[31:28], jumpTarget, 2'b00};

    // no delay slot, target follows the branch directly
    always_comb begin
        case (nextPc)
            PcJump, PcJumpLink: pcNext = jumpAddr;
            PcJumpReg:          pcNext = regTarget;
            default:            pcNext = branchTaken ? branchTarget : pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    // catches jr to a misaligned register value
    pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule

//--- rtl/mipsController.sv
`timescale 1ns/1ps

module mipsController (
    input  logic [5:0]    opcode,
    input  logic [5:0]    funct,
    input  logic [4:0]    rt,
    output mipsPkg::ctrlT ctrl
);
    import mipsPkg::*;

    // memory access width from the load/store opcode
    function automatic accessWidthT accessOf(input logic [5:0] op);
        if (op == OpLw || op == OpSw) begin
            return AccWord;
        end
        if (op == OpLh || op == OpSh) begin
            return AccHalf;
        end
        return AccByte;
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            OpSpecial: begin
                ctrl.regDstRd = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FnAddu: ctrl.aluOp = AluAdd;
                    FnSubu: ctrl.aluOp = AluSub;
                    FnAnd:  ctrl.aluOp = AluAnd;
                    FnOr:   ctrl.aluOp = AluOr;
                    FnXor:  ctrl.aluOp = AluXor;
                    FnSlt:  ctrl.aluOp = AluSlt;
                    FnSll: begin
                        ctrl.aluOp       = AluSll;
                        ctrl.aluSrcShamt = 1'b1;
                    end
                    FnSrl: begin
                        ctrl.aluOp       = AluSrl;
                        ctrl.aluSrcShamt = 1'b1;
                    end
                    FnJr: begin
                        ctrl.nextPc   = PcJumpReg;
                        ctrl.regWrite = 1'b0;
                    end
                    default: ctrl = '0;
                endcase
            end
            OpSpecial2: begin
                // only mul lives here
                if (funct == FnMul) begin
                    ctrl.aluOp    = AluMul;
                    ctrl.regDstRd = 1'b1;
                    ctrl.regWrite = 1'b1;
                end
            end
            OpAddiu, OpSlti, OpOri, OpXori: begin
                ctrl.aluSrcImm  = 1'b1;
                ctrl.regWrite   = 1'b1;
                ctrl.signExtend = (opcode == OpAddiu) || (opcode == OpSlti);
                case (opcode)
                    OpSlti:  ctrl.aluOp = AluSlt;
                    OpOri:   ctrl.aluOp = AluOr;
                    OpXori:  ctrl.aluOp = AluXor;
                    default: ctrl.aluOp = AluAdd;
                endcase
            end
            OpLw, OpLh, OpLb: begin
                ctrl.signExtend  = 1'b1;
                ctrl.aluSrcImm   = 1'b1;
                ctrl.memRead     = 1'b1;
                ctrl.accessWidth = accessOf(opcode);
                ctrl.resultSel   = ResMem;
                ctrl.regWrite    = 1'b1;
            end
            OpSw, OpSh, OpSb: begin
                ctrl.signExtend  = 1'b1;
                ctrl.aluSrcImm   = 1'b1;
                ctrl.memWrite    = 1'b1;
                ctrl.accessWidth = accessOf(opcode);
            end
            // branches compare rs against rt or zero in the ALU
            OpBeq:  ctrl.nextPc = PcBeq;
            OpBne:  ctrl.nextPc = PcBne;
            OpBgtz: ctrl.nextPc = PcBgtz;
            OpBlez: ctrl.nextPc = PcBlez;
            OpRegimm: begin
                case (rt)
                    RtBltz:  ctrl.nextPc = PcBltz;
                    RtBgez:  ctrl.nextPc = PcBgez;
                    default: ctrl.nextPc = PcSeq;
                endcase
            end
            OpJ: ctrl.nextPc = PcJump;
            OpJal: begin
                ctrl.nextPc    = PcJumpLink;
                ctrl.resultSel = ResLink;
                ctrl.regWrite  = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // no opcode may both load and store
    always_comb begin
        assert (!(ctrl.memRead && ctrl.memWrite))
            else $error("memRead and memWrite both set, opcode %h", opcode);
    end

endmodule

//--- rtl/memBus.sv
`timescale 1ns/1ps

interface memBus;
    import mipsPkg::*;

    logic                 readEn;
    logic                 writeEn;
    accessWidthT          width;
    logic [DataWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    // combinational read data, zero when idle
    logic [DataWidth-1:0] rdata;

    modport core (
        output readEn, writeEn, width, addr, wdata,
        input  rdata
    );

    modport mem (
        input  readEn, writeEn, width, addr, wdata,
        output rdata
    );

endinterface

//--- rtl/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////
    // widths and depths
    //////////////////////////////////////////////////
    localparam int DataWidth     = 32;
    localparam int ImemAddrWidth = 8;
    localparam int DmemAddrWidth = 10;
    localparam int ImemDepth     = 2 ** ImemAddrWidth;
    localparam int DmemDepth     = 2 ** DmemAddrWidth;
    localparam int RegCount      = 32;

    // jal destination
    localparam logic [4:0] LinkReg = 5'd31;

    //////////////////////////////////////////////////
    // opcode, funct and regimm rt codes
    //////////////////////////////////////////////////
    localparam logic [5:0] OpSpecial  = 6'b000000;
    localparam logic [5:0] OpRegimm   = 6'b000001;
    localparam logic [5:0] OpJ        = 6'b000010;
    localparam logic [5:0] OpJal      = 6'b000011;
    localparam logic [5:0] OpBeq      = 6'b000100;
    localparam logic [5:0] OpBne      = 6'b000101;
    localparam logic [5:0] OpBlez     = 6'b000110;
    localparam logic [5:0] OpBgtz     = 6'b000111;
    localparam logic [5:0] OpAddiu    = 6'b001001;
    localparam logic [5:0] OpSlti     = 6'b001010;
    localparam logic [5:0] OpOri      = 6'b001101;
    localparam logic [5:0] OpXori     = 6'b001110;
    localparam logic [5:0] OpSpecial2 = 6'b011100;
    localparam logic [5:0] OpLb       = 6'b100000;
    localparam logic [5:0] OpLh       = 6'b100001;
    localparam logic [5:0] OpLw       = 6'b100011;
    localparam logic [5:0] OpSb       = 6'b101000;
    localparam logic [5:0] OpSh       = 6'b101001;
    localparam logic [5:0] OpSw       = 6'b101011;

    localparam logic [5:0] FnSll  = 6'b000000;
    localparam logic [5:0] FnSrl  = 6'b000010;
    localparam logic [5:0] FnJr   = 6'b001000;
    localparam logic [5:0] FnAddu = 6'b100001;
    localparam logic [5:0] FnSubu = 6'b100011;
    localparam logic [5:0] FnAnd  = 6'b100100;
    localparam logic [5:0] FnOr   = 6'b100101;
    localparam logic [5:0] FnXor  = 6'b100110;
    localparam logic [5:0] FnSlt  = 6'b101010;
    // funct of mul inside SPECIAL2
    localparam logic [5:0] FnMul  = 6'b000010;

    localparam logic [4:0] RtBltz = 5'd0;
    localparam logic [4:0] RtBgez = 5'd1;

    //////////////////////////////////////////////////
    // control encodings
    //////////////////////////////////////////////////
    typedef enum logic [3:0] {
        AluAdd, AluSub, AluAnd, AluOr, AluXor, AluSlt, AluSll, AluSrl, AluMul
    } aluOpT;

    typedef enum logic [3:0] {
        PcSeq, PcBeq, PcBne, PcBgtz, PcBlez, PcBltz, PcBgez, PcJump, PcJumpReg, PcJumpLink
    } nextPcT;

    typedef enum logic [1:0] {AccWord, AccHalf, AccByte} accessWidthT;

    typedef enum logic [1:0] {ResAlu, ResMem, ResLink} resultSelT;

    // all zero is a no-op
    typedef struct packed {
        nextPcT      nextPc;
        aluOpT       aluOp;
        logic        signExtend;
        logic        regDstRd;
        logic        aluSrcImm;
        logic        aluSrcShamt;
        logic        memRead;
        logic        memWrite;
        accessWidthT accessWidth;
        resultSelT   resultSel;
        logic        regWrite;
    } ctrlT;

endpackage
